//--- rv32i_pkg.sv
`default_nettype none

package rv32i_pkg;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode;

    typedef enum logic [2:0] {
        f3_add  = 3'b000,
        f3_sll  = 3'b001,
        f3_slt  = 3'b010,
        f3_sltu = 3'b011,
        f3_xor  = 3'b100,
        f3_sr   = 3'b101,
        f3_or   = 3'b110,
        f3_and  = 3'b111
    } arith_funct3_t;

    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_t;

    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_t;

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_sll, alu_sr, alu_xor, alu_or, alu_and
    } alu_op_t;

    typedef enum logic {cmp_lt, cmp_ltu} cmp_op_t;

    typedef enum logic [2:0] {
        rf_alu_out, rf_br_en, rf_u_imm, rf_lw, rf_lb, rf_lbu, rf_lh, rf_lhu
    } regfilemux_t;

    typedef enum logic {src_reg, src_imm} alu_src_t;

    typedef struct packed {
        logic        wb;
        logic        mem_write;
        logic        mem_read;
        alu_op_t     alu_op;
        cmp_op_t     cmp_op;
        alu_src_t    alu_src;
        logic        auipc;
        regfilemux_t regfilemux_sel;
        logic [2:0]  funct3;
    } ctrl_t;

    typedef struct packed {
        rv32i_opcode opcode;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] i_imm;
        logic [31:0] s_imm;
        logic [31:0] u_imm;
        logic        trap;
    } inst_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] rs1_out;
        logic [31:0] rs2_out;
    } data_t;

    typedef struct packed {
        logic  valid;
        inst_t inst;
        data_t data;
        ctrl_t ctrl;
    } packet_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] wdata;
        logic        trap;
    } retire_t;

    // Lowest set rmask bit gives the byte lane
    function automatic logic [31:0] load_extract(input logic [31:0] rdata,
                                                 input logic [3:0] rmask,
                                                 input regfilemux_t sel);
        logic [31:0] s;
        if (rmask[0])
            s = rdata;
        else if (rmask[1])
            s = rdata >> 8;
        else if (rmask[2])
            s = rdata >> 16;
        else
            s = rdata >> 24;
        case (sel)
            rf_lb:   return {{24{s[7]}}, s[7:0]};
            rf_lbu:  return {24'b0, s[7:0]};
            rf_lh:   return {{16{s[15]}}, s[15:0]};
            rf_lhu:  return {16'b0, s[15:0]};
            default: return rdata;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- ctrl_rom.sv
`timescale 1ns/1ns
`default_nettype none

module ctrl_rom (
    input  rv32i_pkg::rv32i_opcode opcode,
    input  logic [2:0]             funct3,
    input  logic [6:0]             funct7,
    output rv32i_pkg::ctrl_t       ctrl
);

    always_comb begin
        ctrl = '0;
        ctrl.funct3 = funct3;
        case (opcode)
            rv32i_pkg::op_lui: begin
                ctrl.wb = 1'b1;
                ctrl.regfilemux_sel = rv32i_pkg::rf_u_imm;
            end
            rv32i_pkg::op_auipc: begin
                ctrl.wb = 1'b1;
                ctrl.auipc = 1'b1;
                ctrl.alu_src = rv32i_pkg::src_imm;
            end
            rv32i_pkg::op_imm, rv32i_pkg::op_reg: begin
                ctrl.wb = 1'b1;
                if (opcode == rv32i_pkg::op_imm)
                    ctrl.alu_src = rv32i_pkg::src_imm;
                case (rv32i_pkg::arith_funct3_t'(funct3))
                    rv32i_pkg::f3_add: begin
                        if (opcode == rv32i_pkg::op_reg && funct7[5])
                            ctrl.alu_op = rv32i_pkg::alu_sub;
                    end
                    rv32i_pkg::f3_sll: ctrl.alu_op = rv32i_pkg::alu_sll;
                    rv32i_pkg::f3_slt: ctrl.regfilemux_sel = rv32i_pkg::rf_br_en;
                    rv32i_pkg::f3_sltu: begin
                        ctrl.regfilemux_sel = rv32i_pkg::rf_br_en;
                        ctrl.cmp_op = rv32i_pkg::cmp_ltu;
                    end
                    rv32i_pkg::f3_xor: ctrl.alu_op = rv32i_pkg::alu_xor;
                    rv32i_pkg::f3_sr:  ctrl.alu_op = rv32i_pkg::alu_sr;
                    rv32i_pkg::f3_or:  ctrl.alu_op = rv32i_pkg::alu_or;
                    default:           ctrl.alu_op = rv32i_pkg::alu_and;
                endcase
            end
            rv32i_pkg::op_load: begin
                ctrl.wb = 1'b1;
                ctrl.mem_read = 1'b1;
                ctrl.alu_src = rv32i_pkg::src_imm;
                case (rv32i_pkg::load_funct3_t'(funct3))
                    rv32i_pkg::lb:  ctrl.regfilemux_sel = rv32i_pkg::rf_lb;
                    rv32i_pkg::lbu: ctrl.regfilemux_sel = rv32i_pkg::rf_lbu;
                    rv32i_pkg::lh:  ctrl.regfilemux_sel = rv32i_pkg::rf_lh;
                    rv32i_pkg::lhu: ctrl.regfilemux_sel = rv32i_pkg::rf_lhu;
                    default:        ctrl.regfilemux_sel = rv32i_pkg::rf_lw;
                endcase
            end
            rv32i_pkg::op_store: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src = rv32i_pkg::src_imm;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- regfile.sv
`timescale 1ns/1ns
`default_nettype none

module regfile (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        we,
    input  logic [4:0]  rd,
    input  logic [31:0] wdata,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    output logic [31:0] reg_a,
    output logic [31:0] reg_b
);

    logic [31:0] regs [32];

    // x0 is cleared at reset and never written
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    assign reg_a = regs[rs1];
    assign reg_b = regs[rs2];

endmodule

`default_nettype wire

//--- decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
    input  logic                   in_valid,
    input  logic [31:0]            in_pc,
    input  logic [31:0]            in_instr,
    output rv32i_pkg::packet_t     id_out,

    input  rv32i_pkg::packet_t     ex_in,
    input  rv32i_pkg::packet_t     mem_in,
    input  rv32i_pkg::packet_t     wb_in,
    input  logic                   br_en,
    input  logic [31:0]            alu_out,
    input  logic [31:0]            data_mem_rdata,
    input  logic [3:0]             rmask,
    input  logic [31:0]            regfile_in,

    output rv32i_pkg::rv32i_opcode opcode,
    output logic [2:0]             funct3,
    output logic [6:0]             funct7,
    input  rv32i_pkg::ctrl_t       ctrl,

    output logic [4:0]             rs1,
    output logic [4:0]             rs2,
    input  logic [31:0]            reg_a,
    input  logic [31:0]            reg_b
);

    logic [31:0] mem_val;
    logic        trap;

    assign opcode = rv32i_pkg::rv32i_opcode'(in_instr[6:0]);
    assign funct3 = in_instr[14:12];
    assign funct7 = in_instr[31:25];
    assign rs1    = in_instr[19:15];
    assign rs2    = in_instr[24:20];

    // A stage can supply src only if it will really write it
    function automatic logic hit(input rv32i_pkg::packet_t p, input logic [4:0] src);
        return p.valid && p.ctrl.wb && !p.inst.trap && p.inst.rd == src && src != 5'd0;
    endfunction

    assign mem_val = rv32i_pkg::load_extract(data_mem_rdata, rmask,
                                             mem_in.ctrl.regfilemux_sel);

    always_comb begin
        trap = 1'b0;
        case (opcode)
            rv32i_pkg::op_lui, rv32i_pkg::op_auipc, rv32i_pkg::op_imm, rv32i_pkg::op_reg: ;
            rv32i_pkg::op_load: begin
                case (rv32i_pkg::load_funct3_t'(funct3))
                    rv32i_pkg::lb, rv32i_pkg::lbu, rv32i_pkg::lh, rv32i_pkg::lhu,
                    rv32i_pkg::lw: ;
                    default: trap = 1'b1;
                endcase
            end
            rv32i_pkg::op_store: begin
                case (rv32i_pkg::store_funct3_t'(funct3))
                    rv32i_pkg::sb, rv32i_pkg::sh, rv32i_pkg::sw: ;
                    default: trap = 1'b1;
                endcase
            end
            // Branches and jumps land here too
            default: trap = 1'b1;
        endcase
    end

    always_comb begin
        id_out.valid       = in_valid;
        id_out.inst.opcode = opcode;
        id_out.inst.funct3 = funct3;
        id_out.inst.funct7 = funct7;
        id_out.inst.rs1    = rs1;
        id_out.inst.rs2    = rs2;
        id_out.inst.rd     = in_instr[11:7];
        id_out.inst.i_imm  = {{21{in_instr[31]}}, in_instr[30:20]};
        id_out.inst.s_imm  = {{21{in_instr[31]}}, in_instr[30:25], in_instr[11:7]};
        id_out.inst.u_imm  = {in_instr[31:12], 12'h000};
        id_out.inst.trap   = trap;
        id_out.ctrl        = ctrl;
        id_out.data.pc     = in_pc;

        // EX beats MEM beats WB beats the register file
        // alu_out already holds the selected EX result
        if (hit(ex_in, rs1))
            id_out.data.rs1_out = alu_out;
        else if (hit(mem_in, rs1))
            id_out.data.rs1_out = mem_val;
        else if (hit(wb_in, rs1))
            id_out.data.rs1_out = regfile_in;
        else
            id_out.data.rs1_out = reg_a;

        if (hit(ex_in, rs2))
            id_out.data.rs2_out = alu_out;
        else if (hit(mem_in, rs2))
            id_out.data.rs2_out = mem_val;
        else if (hit(wb_in, rs2))
            id_out.data.rs2_out = regfile_in;
        else
            id_out.data.rs2_out = reg_b;
    end

endmodule

`default_nettype wire

//--- execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
    input  logic               clk,
    input  logic               arst_n,
    input  rv32i_pkg::packet_t id_in,
    output rv32i_pkg::packet_t ex_pkt,
    output logic [31:0]        alu_out,
    output logic               br_en
);

    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] alu_res;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            ex_pkt <= '0;
        else
            ex_pkt <= id_in;
    end

    always_comb begin
        if (ex_pkt.ctrl.mem_write)
            imm = ex_pkt.inst.s_imm;
        else if (ex_pkt.ctrl.auipc)
            imm = ex_pkt.inst.u_imm;
        else
            imm = ex_pkt.inst.i_imm;
    end

    assign a = ex_pkt.ctrl.auipc ? ex_pkt.data.pc : ex_pkt.data.rs1_out;
    assign b = (ex_pkt.ctrl.alu_src == rv32i_pkg::src_imm) ? imm : ex_pkt.data.rs2_out;

    always_comb begin
        case (ex_pkt.ctrl.alu_op)
            rv32i_pkg::alu_sub: alu_res = a - b;
            rv32i_pkg::alu_sll: alu_res = a << b[4:0];
            rv32i_pkg::alu_sr: begin
                if (ex_pkt.inst.funct7[5])
                    alu_res = $unsigned($signed(a) >>> b[4:0]);
                else
                    alu_res = a >> b[4:0];
            end
            rv32i_pkg::alu_xor: alu_res = a ^ b;
            rv32i_pkg::alu_or:  alu_res = a | b;
            rv32i_pkg::alu_and: alu_res = a & b;
            default:            alu_res = a + b;
        endcase
    end

    assign br_en = (ex_pkt.ctrl.cmp_op == rv32i_pkg::cmp_ltu) ? (a < b)
                                                               : ($signed(a) < $signed(b));

    // alu_out carries the full EX result on to MEM
    always_comb begin
        case (ex_pkt.ctrl.regfilemux_sel)
            rv32i_pkg::rf_br_en: alu_out = {31'b0, br_en};
            rv32i_pkg::rf_u_imm: alu_out = ex_pkt.inst.u_imm;
            default:             alu_out = alu_res;
        endcase
    end

endmodule

`default_nettype wire

//--- mem_stage.sv
`timescale 1ns/1ns
`default_nettype none

module mem_stage #(
    parameter int DMEM_WORDS = 64
) (
    input  logic               clk,
    input  logic               arst_n,
    input  rv32i_pkg::packet_t ex_in,
    input  logic [31:0]        alu_out,
    output rv32i_pkg::packet_t mem_pkt,
    output logic [31:0]        mem_addr,
    output logic [31:0]        data_mem_rdata,
    output logic [3:0]         rmask
);

    localparam int AW = $clog2(DMEM_WORDS);

    logic [31:0]   dmem [DMEM_WORDS];
    logic [AW-1:0] idx;
    logic [3:0]    lane;
    logic [31:0]   wdata;
    logic          store_en;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_pkt  <= '0;
            mem_addr <= '0;
        end else begin
            mem_pkt  <= ex_in;
            mem_addr <= alu_out;
        end
    end

    // Word index wraps modulo the memory depth
    assign idx = mem_addr[AW+1:2];

    // Halfwords ignore bit 0, so every mask is legal
    always_comb begin
        case (mem_pkt.ctrl.funct3[1:0])
            2'b00: begin
                lane  = 4'b0001 << mem_addr[1:0];
                wdata = {4{mem_pkt.data.rs2_out[7:0]}};
            end
            2'b01: begin
                lane  = mem_addr[1] ? 4'b1100 : 4'b0011;
                wdata = {2{mem_pkt.data.rs2_out[15:0]}};
            end
            default: begin
                lane  = 4'b1111;
                wdata = mem_pkt.data.rs2_out;
            end
        endcase
    end

    assign store_en = mem_pkt.valid && mem_pkt.ctrl.mem_write && !mem_pkt.inst.trap;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < DMEM_WORDS; i++)
                dmem[i] <= '0;
        end else if (store_en) begin
            for (int k = 0; k < 4; k++) begin
                if (lane[k])
                    dmem[idx][8*k +: 8] <= wdata[8*k +: 8];
            end
        end
    end

    assign rmask = mem_pkt.ctrl.mem_read ? lane : 4'b0000;

    // Non-loads pass their EX result on the read-data path
    assign data_mem_rdata = mem_pkt.ctrl.mem_read ? dmem[idx] : mem_addr;

endmodule

`default_nettype wire

//--- writeback_stage.sv
`timescale 1ns/1ns
`default_nettype none

module writeback_stage (
    input  logic               clk,
    input  logic               arst_n,
    input  rv32i_pkg::packet_t mem_in,
    input  logic [31:0]        mem_addr,
    input  logic [31:0]        data_mem_rdata,
    input  logic [3:0]         rmask,
    output rv32i_pkg::packet_t wb_pkt,
    output logic [31:0]        regfile_in,
    output logic               rf_we,
    output rv32i_pkg::retire_t retire
);

    logic [31:0] mem_result;

    assign mem_result = mem_in.ctrl.mem_read
        ? rv32i_pkg::load_extract(data_mem_rdata, rmask, mem_in.ctrl.regfilemux_sel)
        : mem_addr;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_pkt     <= '0;
            regfile_in <= '0;
        end else begin
            wb_pkt     <= mem_in;
            regfile_in <= mem_result;
        end
    end

    assign rf_we = wb_pkt.valid && wb_pkt.ctrl.wb && !wb_pkt.inst.trap;

    always_comb begin
        retire.valid = wb_pkt.valid;
        retire.pc    = wb_pkt.data.pc;
        retire.rd    = wb_pkt.inst.rd;
        retire.wdata = rf_we ? regfile_in : 32'b0;
        retire.trap  = wb_pkt.inst.trap;
    end

endmodule

`default_nettype wire

//--- rv32i_core.sv
`timescale 1ns/1ns
`default_nettype none

module rv32i_core #(
    parameter int DMEM_WORDS = 64
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               in_valid,
    input  logic [31:0]        in_pc,
    input  logic [31:0]        in_instr,
    output rv32i_pkg::retire_t retire
);

    rv32i_pkg::packet_t     id_out;
    rv32i_pkg::packet_t     ex_pkt;
    rv32i_pkg::packet_t     mem_pkt;
    rv32i_pkg::packet_t     wb_pkt;
    rv32i_pkg::ctrl_t       ctrl;
    rv32i_pkg::rv32i_opcode opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    logic [4:0]             rs1;
    logic [4:0]             rs2;
    logic [31:0]            reg_a;
    logic [31:0]            reg_b;
    logic [31:0]            alu_out;
    logic                   br_en;
    logic [31:0]            mem_addr;
    logic [31:0]            data_mem_rdata;
    logic [3:0]             rmask;
    logic [31:0]            regfile_in;
    logic                   rf_we;

    decode_stage decode_i (
        .in_valid(in_valid), .in_pc(in_pc), .in_instr(in_instr), .id_out(id_out),
        .ex_in(ex_pkt), .mem_in(mem_pkt), .wb_in(wb_pkt),
        .br_en(br_en), .alu_out(alu_out), .data_mem_rdata(data_mem_rdata),
        .rmask(rmask), .regfile_in(regfile_in),
        .opcode(opcode), .funct3(funct3), .funct7(funct7), .ctrl(ctrl),
        .rs1(rs1), .rs2(rs2), .reg_a(reg_a), .reg_b(reg_b)
    );

    ctrl_rom ctrl_rom_i (.opcode(opcode), .funct3(funct3), .funct7(funct7), .ctrl(ctrl));

    regfile regfile_i (
        .clk(clk), .arst_n(arst_n), .we(rf_we), .rd(wb_pkt.inst.rd), .wdata(regfile_in),
        .rs1(rs1), .rs2(rs2), .reg_a(reg_a), .reg_b(reg_b)
    );

    execute_stage execute_i (
        .clk(clk), .arst_n(arst_n), .id_in(id_out), .ex_pkt(ex_pkt),
        .alu_out(alu_out), .br_en(br_en)
    );

    mem_stage #(.DMEM_WORDS(DMEM_WORDS)) mem_i (
        .clk(clk), .arst_n(arst_n), .ex_in(ex_pkt), .alu_out(alu_out), .mem_pkt(mem_pkt),
        .mem_addr(mem_addr), .data_mem_rdata(data_mem_rdata), .rmask(rmask)
    );

    writeback_stage writeback_i (
        .clk(clk), .arst_n(arst_n), .mem_in(mem_pkt), .mem_addr(mem_addr),
        .data_mem_rdata(data_mem_rdata), .rmask(rmask), .wb_pkt(wb_pkt),
        .regfile_in(regfile_in), .rf_we(rf_we), .retire(retire)
    );

endmodule

`default_nettype wire

//--- tb_clkgen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

//--- tb_rv32i_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_rv32i_core;

    localparam int DMEM_WORDS   = 64;
    localparam int RESET_CYCLES = 10;
    localparam int PROG_LEN     = 600;
    localparam int MAX_CYCLES   = RESET_CYCLES + PROG_LEN + 20;

    typedef struct packed {
        rv32i_pkg::retire_t r;
        logic [31:0]        cyc;
    } expect_t;

    logic               clk;
    logic               arst_n;
    logic               in_valid;
    logic [31:0]        in_pc;
    logic [31:0]        in_instr;
    rv32i_pkg::retire_t retire;

    logic [31:0] ref_regs [32];
    logic [31:0] ref_mem [DMEM_WORDS];
    logic        prog_valid [PROG_LEN];
    logic [31:0] prog_instr [PROG_LEN];
    int          prog_n = 0;
    int          last_load = -1;
    int          cycle = 0;
    int          seed;
    expect_t     exp_q [$];

    tb_clkgen #(.PERIOD(20)) clkgen_i (.clk(clk));

    rv32i_core #(.DMEM_WORDS(DMEM_WORDS)) dut_i (
        .clk(clk), .arst_n(arst_n), .in_valid(in_valid), .in_pc(in_pc),
        .in_instr(in_instr), .retire(retire)
    );

    task automatic stop_failed();
        $display("TEST FAILED");
        $fatal(1, "run stopped on error");
    endtask

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_failed();
        end
    endtask

    function automatic int rnd(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    // Registers base..base+3
    function automatic logic [31:0] rand_alu(input int base);
        logic [4:0] rd;
        logic [4:0] ra;
        logic [4:0] rb;
        logic [2:0] f3;
        logic [6:0] f7;
        int         k;
        rd = 5'(base + rnd(4));
        ra = 5'(base + rnd(4));
        rb = 5'(base + rnd(4));
        f3 = 3'(rnd(8));
        f7 = (rnd(2) == 1) ? 7'h20 : 7'h00;
        k  = rnd(8);
        if (k == 0)
            return enc_u(20'($random(seed)), rd, 7'h37);
        else if (k == 1)
            return enc_u(20'($random(seed)), rd, 7'h17);
        else if (k < 5 && (f3 == 3'b001 || f3 == 3'b101))
            return enc_i({(f3 == 3'b101) ? f7 : 7'h00, 5'(rnd(32))}, ra, f3, rd, 7'h13);
        else if (k < 5)
            return enc_i(12'($random(seed)), ra, f3, rd, 7'h13);
        return enc_i({f7, rb}, ra, f3, rd, 7'h33);
    endfunction

    // Half the accesses use x0 as base to hit a few words often
    function automatic logic [31:0] rand_mem();
        logic [4:0]  rd;
        logic [4:0]  base;
        logic [11:0] imm;
        logic [2:0]  f3;
        rd   = 5'(rnd(4));
        base = (rnd(2) == 1) ? 5'd0 : 5'(rnd(4));
        imm  = (base == 5'd0) ? 12'(rnd(32)) : 12'($random(seed));
        if (rnd(2) == 1) begin
            f3 = 3'(rnd(5));
            if (f3 > 3'd2)
                f3 = f3 + 3'd1;
            return enc_i(imm, base, f3, rd, 7'h03);
        end
        return enc_s(imm, 5'(rnd(4)), base, 3'(rnd(3)));
    endfunction

    function automatic logic [31:0] rand_trap();
        logic [31:0] w;
        int          k;
        w = $random(seed);
        k = rnd(6);
        case (k)
            0: w[6:0] = 7'h63;
            1: w[6:0] = 7'h6f;
            2: w[6:0] = 7'h67;
            3: w[6:0] = 7'h0f;
            4: begin
                w[6:0]   = 7'h03;
                w[14:12] = (rnd(3) == 0) ? 3'd3 : ((rnd(2) == 0) ? 3'd6 : 3'd7);
            end
            default: begin
                w[6:0]   = 7'h23;
                w[14:12] = 3'(3 + rnd(5));
            end
        endcase
        return w;
    endfunction

    task automatic add_slot(input logic v, input logic [31:0] ins);
        if (prog_n < PROG_LEN) begin
            prog_valid[prog_n] = v;
            prog_instr[prog_n] = ins;
            prog_n++;
        end
    endtask

    task automatic bubble();
        add_slot(1'b0, $random(seed));
        last_load = -1;
    endtask

    // Load data comes back from MEM, so a consumer sits two slots behind
    task automatic emit(input logic [31:0] ins);
        if (last_load >= 0 && (int'(ins[19:15]) == last_load || int'(ins[24:20]) == last_load))
            bubble();
        add_slot(1'b1, ins);
        last_load = (ins[6:0] == 7'h03) ? int'(ins[11:7]) : -1;
    endtask

    task automatic build_program();
        int r;
        // Every store width, then every load width, at each byte offset
        for (int off = 0; off < 4; off++) begin
            for (int sw = 0; sw < 3; sw++) begin
                emit(enc_u(20'($random(seed)), 5'd1, 7'h37));
                emit(enc_i(12'($random(seed)), 5'd1, 3'b100, 5'd1, 7'h13));
                emit(enc_s(12'(16 + off), 5'd1, 5'd0, 3'(sw)));
                for (int k = 0; k < 5; k++)
                    emit(enc_i(12'(16 + off), 5'd0, 3'(k + ((k > 2) ? 1 : 0)), 5'd2, 7'h03));
                emit(enc_i({7'h00, 5'd2}, 5'd2, 3'b000, 5'd3, 7'h33));
            end
        end
        // Spaced ALU ops on x8..x11
        for (int i = 0; i < 20; i++) begin
            emit(rand_alu(8));
            bubble();
            bubble();
            bubble();
        end
        while (prog_n < PROG_LEN - 2) begin
            r = rnd(16);
            if (r < 2)
                bubble();
            else if (r < 9)
                emit(rand_alu(0));
            else if (r < 14)
                emit(rand_mem());
            else
                emit(rand_trap());
        end
    endtask

    function automatic rv32i_pkg::retire_t ref_exec(input logic [31:0] pc,
                                                     input logic [31:0] ins);
        rv32i_pkg::retire_t r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] word;
        logic [7:0]  bval;
        logic [15:0] hval;
        logic [2:0]  f3;
        logic        wr;
        int          idx;
        a       = ref_regs[ins[19:15]];
        b       = ref_regs[ins[24:20]];
        f3      = ins[14:12];
        r.valid = 1'b1;
        r.pc    = pc;
        r.rd    = ins[11:7];
        r.wdata = 32'b0;
        r.trap  = 1'b0;
        wr      = 1'b1;
        res     = 32'b0;
        case (ins[6:0])
            7'h37: res = {ins[31:12], 12'b0};
            7'h17: res = pc + {ins[31:12], 12'b0};
            7'h13, 7'h33: begin
                if (ins[6:0] == 7'h13)
                    b = {{20{ins[31]}}, ins[31:20]};
                case (f3)
                    3'b000:  res = (ins[6:0] == 7'h33 && ins[30]) ? a - b : a + b;
                    3'b001:  res = a << b[4:0];
                    3'b010:  res = {31'b0, $signed(a) < $signed(b)};
                    3'b011:  res = {31'b0, a < b};
                    3'b100:  res = a ^ b;
                    3'b101:  res = ins[30] ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
                    3'b110:  res = a | b;
                    default: res = a & b;
                endcase
            end
            7'h03: begin
                addr = a + {{20{ins[31]}}, ins[31:20]};
                word = ref_mem[(addr >> 2) % DMEM_WORDS];
                bval = 8'(word >> (8 * addr[1:0]));
                hval = 16'(word >> (16 * addr[1]));
                case (f3)
                    3'b000:  res = {{24{bval[7]}}, bval};
                    3'b001:  res = {{16{hval[15]}}, hval};
                    3'b010:  res = word;
                    3'b100:  res = {24'b0, bval};
                    3'b101:  res = {16'b0, hval};
                    default: r.trap = 1'b1;
                endcase
            end
            7'h23: begin
                wr   = 1'b0;
                addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                idx  = (addr >> 2) % DMEM_WORDS;
                case (f3)
                    3'b000:  ref_mem[idx][8 * addr[1:0] +: 8] = b[7:0];
                    3'b001:  ref_mem[idx][16 * addr[1] +: 16] = b[15:0];
                    3'b010:  ref_mem[idx] = b;
                    default: r.trap = 1'b1;
                endcase
            end
            default: r.trap = 1'b1;
        endcase
        if (!r.trap && wr) begin
            r.wdata = res;
            if (ins[11:7] != 5'd0)
                ref_regs[ins[11:7]] = res;
        end
        return r;
    endfunction

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles with %0d retires still pending", cycle,
                     exp_q.size());
            stop_failed();
        end
    end

    // Retire is sampled mid-cycle
    always @(negedge clk) begin : compare
        expect_t e;
        if (retire.valid) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected retire of pc %h in cycle %0d", retire.pc, cycle);
                stop_failed();
            end else begin
                e = exp_q.pop_front();
                check_eq("retire cycle", 32'(cycle), e.cyc);
                check_eq("retire.pc", retire.pc, e.r.pc);
                check_eq("retire.rd", {27'b0, retire.rd}, {27'b0, e.r.rd});
                check_eq("retire.wdata", retire.wdata, e.r.wdata);
                check_eq("retire.trap", {31'b0, retire.trap}, {31'b0, e.r.trap});
            end
        end else if (exp_q.size() != 0 && exp_q[0].cyc == 32'(cycle)) begin
            $display("No retire of pc %h in cycle %0d", exp_q[0].r.pc, cycle);
            stop_failed();
        end
    end

    initial begin
        expect_t e;
        seed     = 32'h2b7e;
        arst_n   = 1'b0;
        in_valid = 1'b0;
        in_pc    = 32'b0;
        in_instr = 32'b0;
        for (int i = 0; i < 32; i++)
            ref_regs[i] = 32'b0;
        for (int i = 0; i < DMEM_WORDS; i++)
            ref_mem[i] = 32'b0;
        build_program();
        repeat (RESET_CYCLES) @(posedge clk);
        #2 arst_n = 1'b1;
        for (int i = 0; i < prog_n; i++) begin
            @(posedge clk);
            #2;
            in_valid = prog_valid[i];
            in_pc    = 32'h1000 + 4 * i;
            in_instr = prog_instr[i];
            if (prog_valid[i]) begin
                e.r   = ref_exec(in_pc, in_instr);
                e.cyc = 32'(cycle + 3);
                exp_q.push_back(e);
            end
        end
        @(posedge clk);
        #2 in_valid = 1'b0;
        while (exp_q.size() != 0)
            @(negedge clk);
        // A few idle cycles to catch any stray retire
        repeat (3) @(negedge clk);
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- rv32i_core.f
rv32i_pkg.sv
ctrl_rom.sv
regfile.sv
decode_stage.sv
execute_stage.sv
mem_stage.sv
writeback_stage.sv
rv32i_core.sv
tb_clkgen.sv
tb_rv32i_core.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_rv32i_core
FILELIST  ?= rv32i_core.f
OBJDIR    ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
